//--- hw/capture_macros.svh
`ifndef CAPTURE_MACROS_SVH
`define CAPTURE_MACROS_SVH

//////////////////////////////
// sample side widths
//////////////////////////////

// one adc channel sample
`define ADC_BITS 12

// fifo word, also the psram data width
`define WORD_BITS 16

// write fifo, 512 words deep
`define FIFO_DEPTH 512
`define FIFO_AW 9 // log2 of depth

//////////////////////////////
// memory side sizes
//////////////////////////////

// words per write burst, doubles as almost empty threshold
`define BURST_WORDS 8
`define BURST_BYTES 16 // 8 words x 2 bytes

// pretrigger window, 64 bursts behind the pwm edge
`define PRETRIGGER_BYTES 1024

`define ADDR_BITS 25 // psram byte address

`endif

//--- hw/capture_pkg.sv
`default_nettype none

`include "capture_macros.svh"

package capture_pkg;

	//////////////////////////////
	// adc frame and fifo words
	//////////////////////////////

	// one strobed frame from both converters
	typedef struct packed {
		logic [`ADC_BITS-1:0] a0; // output current
		logic [`ADC_BITS-1:0] a1; // cap voltage
		logic [`ADC_BITS-1:0] b0; // cap current
		logic [`ADC_BITS-1:0] b1; // output voltage
	} adc_frame_t;

	// one fifo word, tag nibble over a 12 bit sample
	typedef struct packed {
		logic [3:0] tag; // iest slice or pwm
		logic [`ADC_BITS-1:0] value;
	} sample_word_t;

	// packer position, also the order words leave in
	typedef enum logic [1:0] {
		SLOT_A0, // idle, next strobe sends a0
		SLOT_A1,
		SLOT_B0,
		SLOT_B1
	} slot_t;

endpackage

`default_nettype wire

//--- hw/psram_pkg.sv
`default_nettype none

`include "capture_macros.svh"

package psram_pkg;

	//////////////////////////////
	// psram write side
	//////////////////////////////

	typedef logic [`ADDR_BITS-1:0] addr_t; // byte address

	// write request toward the psram controller
	typedef struct packed {
		logic valid; // burst of 8 words waiting
		addr_t addr; // start byte address
	} write_req_t;

	// burst writer states
	typedef enum logic {
		CAPTURING, // normal streaming
		HALTED // pretrigger window closed
	} writer_state_t;

endpackage

`default_nettype wire

//--- hw/sample_packer.sv
`timescale 1ns/1ps
`default_nettype none

`include "capture_macros.svh"

module sample_packer (
	input  logic clk,
	input  logic reset,
	input  logic ad_strobe, // frame strobe, one cycle
	input  logic psram_ready, // capture only while memory is up
	input  capture_pkg::adc_frame_t ad_frame,
	input  logic [`ADC_BITS-1:0] iest, // coil current estimate
	input  logic pwm,
	output capture_pkg::sample_word_t word,
	output logic we
);

	capture_pkg::slot_t slot; // word due next cycle, A0 means idle
	capture_pkg::adc_frame_t frame_q; // held frame
	logic [7:0] iest_q; // low 8 bits, top nibble rides with A0
	logic pwm_q; // pwm at the strobe
	logic take; // strobe that is captured

	assign take = ad_strobe & psram_ready;

	//////////////////////////////
	// frame hold
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (take) begin
			frame_q <= ad_frame;
			iest_q <= iest[7:0];
			pwm_q <= pwm;
		end
	end

	// A0 goes out live, then A1, B0, B1 one per cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			slot <= capture_pkg::SLOT_A0;
		end else begin
			case (slot)
				capture_pkg::SLOT_A0: slot <= take ? capture_pkg::SLOT_A1 : capture_pkg::SLOT_A0;
				capture_pkg::SLOT_A1: slot <= capture_pkg::SLOT_B0;
				capture_pkg::SLOT_B0: slot <= capture_pkg::SLOT_B1;
				default: slot <= capture_pkg::SLOT_A0; // B1 done, back to idle
			endcase
		end
	end

	//////////////////////////////
	// word mux
	//////////////////////////////

	always_comb begin
		case (slot)
			capture_pkg::SLOT_A0: begin
				word.tag = iest[11:8]; // straight from the strobe cycle
				word.value = ad_frame.a0;
			end
			capture_pkg::SLOT_A1: begin
				word.tag = iest_q[7:4];
				word.value = frame_q.a1;
			end
			capture_pkg::SLOT_B0: begin
				word.tag = iest_q[3:0];
				word.value = frame_q.b0;
			end
			default: begin
				word.tag = {3'b000, pwm_q}; // pwm flag on the last word
				word.value = frame_q.b1;
			end
		endcase
	end

	assign we = take | (slot != capture_pkg::SLOT_A0); // trailing words always written

	// next strobe must wait until B1 has gone
	a_no_overlap: assert property (@(posedge clk) disable iff (reset)
		ad_strobe |-> slot == capture_pkg::SLOT_A0);

endmodule

`default_nettype wire

//--- hw/sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "capture_macros.svh"

module sample_fifo (
	input  logic clk,
	input  logic reset,
	input  logic we, // push
	input  capture_pkg::sample_word_t word,
	input  logic re, // pop, ignored when empty
	output logic [`WORD_BITS-1:0] q, // head word, fall through
	output logic empty,
	output logic almost_empty, // fewer than a burst waiting
	output logic overflow // sticky
);

	logic [`WORD_BITS-1:0] mem [`FIFO_DEPTH];
	logic [`FIFO_AW:0] wr_ptr; // top bit is the wrap flag
	logic [`FIFO_AW:0] rd_ptr;
	logic [`FIFO_AW:0] level; // 0 to FIFO_DEPTH
	logic full;
	logic push;
	logic pop;

	//////////////////////////////
	// status
	//////////////////////////////

	assign full = level == `FIFO_DEPTH;
	assign push = we & ~full; // write into full is lost
	assign pop = re & ~empty;

	assign empty = wr_ptr == rd_ptr; // same lap, same slot
	assign almost_empty = level < `BURST_WORDS;

	assign q = mem[rd_ptr[`FIFO_AW-1:0]];

	// storage
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr[`FIFO_AW-1:0]] <= word;
		end
	end

	//////////////////////////////
	// pointers and level
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
			overflow <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level; // both or neither
			endcase
			if (we && full) begin
				overflow <= 1'b1; // held until reset
			end
		end
	end

	a_level_max: assert property (@(posedge clk) disable iff (reset)
		level <= `FIFO_DEPTH);

	// pointer compare and counter must tell the same story
	a_empty_level: assert property (@(posedge clk) disable iff (reset)
		empty == (level == '0));

endmodule

`default_nettype wire

//--- hw/burst_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "capture_macros.svh"

module burst_writer (
	input  logic clk,
	input  logic reset,
	input  logic almost_empty, // from fifo
	input  logic awready, // controller took the request
	input  logic pwm,
	input  logic halt, // stop at the pretrigger base
	output psram_pkg::write_req_t awreq,
	output psram_pkg::addr_t base_addr
);

	psram_pkg::writer_state_t state;
	psram_pkg::writer_state_t state_next;
	psram_pkg::addr_t addr; // next burst address
	logic valid;
	logic pwm_d;
	logic pwm_rise;
	logic wrap_hit; // back around to the base

	assign pwm_rise = pwm & ~pwm_d;
	assign wrap_hit = halt && (addr == base_addr);
	assign state_next = wrap_hit ? psram_pkg::HALTED : state; // no way back out

	assign awreq.valid = valid;
	assign awreq.addr = addr;

	//////////////////////////////
	// request, address, base
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= psram_pkg::CAPTURING;
			valid <= 1'b0;
			addr <= '0;
			base_addr <= '0;
			pwm_d <= 1'b0;
		end else begin
			state <= state_next;
			// a burst is ready once 8 words sit in the fifo
			valid <= (state_next == psram_pkg::CAPTURING) && !almost_empty;
			if (valid && awready) begin
				addr <= addr + psram_pkg::addr_t'(`BURST_BYTES); // one burst on
			end
			// base trails the write point by the pretrigger window, wraps mod 2^25
			if (pwm_rise && !halt) begin
				base_addr <= addr - psram_pkg::addr_t'(`PRETRIGGER_BYTES);
			end
			pwm_d <= pwm;
		end
	end

	// controller samples addr while request waits
	a_addr_hold: assert property (@(posedge clk) disable iff (reset)
		(awreq.valid && !awready) |=> $stable(awreq.addr));

endmodule

`default_nettype wire

//--- hw/adc_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "capture_macros.svh"

module adc_capture_top (
	input  logic clk,
	input  logic reset,
	input  logic ad_strobe,
	input  logic psram_ready,
	input  capture_pkg::adc_frame_t ad_frame,
	input  logic [`ADC_BITS-1:0] iest,
	input  logic pwm,
	input  logic halt,
	input  logic wready, // psram pops one word
	output logic [`WORD_BITS-1:0] wdata,
	input  logic awready,
	output psram_pkg::write_req_t awreq,
	output psram_pkg::addr_t base_addr,
	output logic overflow
);

	capture_pkg::sample_word_t word; // packer to fifo
	logic we;
	logic almost_empty; // fifo to writer

	//////////////////////////////
	// capture path
	//////////////////////////////

	sample_packer sample_packer_i (
		.clk(clk),
		.reset(reset),
		.ad_strobe(ad_strobe),
		.psram_ready(psram_ready),
		.ad_frame(ad_frame),
		.iest(iest),
		.pwm(pwm),
		.word(word),
		.we(we)
	);

	sample_fifo sample_fifo_i (
		.clk(clk),
		.reset(reset),
		.we(we),
		.word(word),
		.re(wready),
		.q(wdata),
		.empty(), // head valid is implied by the request
		.almost_empty(almost_empty),
		.overflow(overflow)
	);

	burst_writer burst_writer_i (
		.clk(clk),
		.reset(reset),
		.almost_empty(almost_empty),
		.awready(awready),
		.pwm(pwm),
		.halt(halt),
		.awreq(awreq),
		.base_addr(base_addr)
	);

endmodule

`default_nettype wire

//--- verif/adc_capture_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "capture_macros.svh"

module adc_capture_tb;

	logic clk = 1'b0;
	logic reset;
	logic ad_strobe;
	logic psram_ready;
	capture_pkg::adc_frame_t ad_frame;
	logic [`ADC_BITS-1:0] iest;
	logic pwm;
	logic halt;
	logic wready;
	logic [`WORD_BITS-1:0] wdata;
	logic awready;
	psram_pkg::write_req_t awreq;
	psram_pkg::addr_t base_addr;
	logic overflow;

	// reference model state after the last rising edge
	logic [`WORD_BITS-1:0] fifo_q[$]; // words the fifo holds
	logic [`WORD_BITS-1:0] pend[$]; // trailing words of the frame in flight
	logic valid_m;
	logic [`ADDR_BITS-1:0] addr_m;
	logic [`ADDR_BITS-1:0] base_m;
	logic halted_m;
	logic pwm_d_m;
	logic overflow_m;
	logic model_ok = 1'b0; // set at the first reset edge
	int pops_checked = 0;
	int gap_left; // cycles until the next strobe may go
	int wait_cycles;

	always #10 clk = ~clk; // 20 ns period

	adc_capture_top adc_capture_top_i (
		.clk(clk),
		.reset(reset),
		.ad_strobe(ad_strobe),
		.psram_ready(psram_ready),
		.ad_frame(ad_frame),
		.iest(iest),
		.pwm(pwm),
		.halt(halt),
		.wready(wready),
		.wdata(wdata),
		.awready(awready),
		.awreq(awreq),
		.base_addr(base_addr),
		.overflow(overflow)
	);

	task automatic stop_run();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERROR t=%0t %s got %0h expected %0h", $time, name, got, exp);
			stop_run();
		end
	endtask

	//////////////////////////////
	// reference model
	//////////////////////////////

	task automatic reset_model();
		fifo_q.delete();
		pend.delete();
		valid_m = 1'b0;
		addr_m = '0;
		base_m = '0;
		halted_m = 1'b0;
		pwm_d_m = 1'b0;
		overflow_m = 1'b0;
	endtask

	// one rising edge with the inputs the DUT samples there
	task automatic step_model();
		logic we_m;
		logic [`WORD_BITS-1:0] word_m;
		logic full_m;
		logic halt_next;
		we_m = 1'b0;
		word_m = '0;
		if (pend.size() > 0) begin
			word_m = pend.pop_front(); // A1, B0, B1 in turn
			we_m = 1'b1;
		end else if (ad_strobe && psram_ready) begin
			word_m = {iest[11:8], ad_frame.a0}; // A0 in the strobe cycle
			pend.push_back({iest[7:4], ad_frame.a1});
			pend.push_back({iest[3:0], ad_frame.b0});
			pend.push_back({3'b000, pwm, ad_frame.b1});
			we_m = 1'b1;
		end
		full_m = fifo_q.size() == `FIFO_DEPTH;
		halt_next = halted_m || (halt && addr_m == base_m);
		if (pwm && !pwm_d_m && !halt) begin
			base_m = addr_m - `PRETRIGGER_BYTES; // wraps mod 2^25
		end
		if (valid_m && awready) begin
			addr_m = addr_m + `BURST_BYTES;
		end
		// level before this edge decides the request
		valid_m = !halt_next && fifo_q.size() >= `BURST_WORDS;
		halted_m = halt_next;
		pwm_d_m = pwm;
		if (wready && fifo_q.size() > 0) begin
			void'(fifo_q.pop_front());
		end
		if (we_m && full_m) begin
			overflow_m = 1'b1; // word lost
		end else if (we_m) begin
			fifo_q.push_back(word_m);
		end
	endtask

	// outputs are settled at the falling edge
	always @(negedge clk) begin
		if (model_ok) begin
			if (fifo_q.size() > 0) begin
				check_value("wdata", wdata, fifo_q[0]);
				if (wready) begin
					pops_checked++;
				end
			end
			check_value("awreq.valid", awreq.valid, valid_m);
			check_value("awreq.addr", awreq.addr, addr_m);
			check_value("base_addr", base_addr, base_m);
			check_value("overflow", overflow, overflow_m);
		end
		if (reset) begin
			reset_model();
			model_ok = 1'b1;
		end else if (model_ok) begin
			step_model();
		end
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////

	task automatic drive_cycle(input int wready_pct);
		logic [63:0] rnd;
		@(posedge clk);
		rnd = {$urandom, $urandom};
		wready <= ($urandom % 100) < wready_pct;
		awready <= ($urandom % 100) < 70; // some back-pressure
		psram_ready <= ($urandom % 100) < 85;
		if ($urandom % 40 == 0) begin
			pwm <= ~pwm; // slow pwm with edges every few dozen cycles
		end
		iest <= rnd[59:48];
		ad_frame <= rnd[47:0];
		if (gap_left == 0) begin
			ad_strobe <= 1'b1;
			gap_left = 3 + $urandom % 7; // strobes 4 to 10 cycles apart
		end else begin
			ad_strobe <= 1'b0;
			gap_left--;
		end
	endtask

	initial begin
		void'($urandom(32'h26750912));
		reset = 1'b1;
		ad_strobe = 1'b0;
		psram_ready = 1'b0;
		ad_frame = '0;
		iest = '0;
		pwm = 1'b0;
		halt = 1'b0;
		wready = 1'b0;
		awready = 1'b0;
		gap_left = 0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		repeat (2000) drive_cycle(45); // level wanders around a burst

		// drain stopped until the fifo overflows
		wait_cycles = 0;
		while (!overflow_m && wait_cycles < 3000) begin
			drive_cycle(0);
			wait_cycles++;
		end
		if (!overflow_m) begin
			$display("overflow never set while wready was held low");
			stop_run();
		end
		repeat (200) drive_cycle(0); // more lost words
		repeat (1500) drive_cycle(90);

		// second reset with halt up so addr and base meet at 0
		@(posedge clk);
		reset <= 1'b1;
		halt <= 1'b1;
		ad_strobe <= 1'b0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		wait_cycles = 0;
		while (!halted_m && wait_cycles < 50) begin
			drive_cycle(45);
			wait_cycles++;
		end
		if (!halted_m) begin
			$display("writer never reached the halted state");
			stop_run();
		end
		repeat (400) drive_cycle(0); // fifo fills, valid must stay low
		if (fifo_q.size() < `BURST_WORDS) begin
			$display("fifo never held a full burst while the writer was halted");
			stop_run();
		end

		if (pops_checked < 100) begin
			$display("too few words popped to check the data path");
			stop_run();
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- adc_capture.f
+incdir+hw
hw/capture_pkg.sv
hw/psram_pkg.sv
hw/sample_packer.sv
hw/sample_fifo.sv
hw/burst_writer.sv
hw/adc_capture_top.sv
verif/adc_capture_tb.sv

//--- Bender.yml
package:
  name: adc_capture

sources:
  - include_dirs:
      - hw
    files:
      - hw/capture_pkg.sv
      - hw/psram_pkg.sv
      - hw/sample_packer.sv
      - hw/sample_fifo.sv
      - hw/burst_writer.sv
      - hw/adc_capture_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/adc_capture_tb.sv
